// ==== Bender.yml ====
package:
  name: core

export_include_dirs:
  - hw

sources:
  - files:
      - hw/core_pkg.sv
      - hw/core_decode.sv
      - hw/core_execute.sv
      - hw/core_result.sv
      - hw/core_top.sv
  - target: simulation
    files:
      - sim/core_props.sv
      - sim/core_tb.sv

// ==== core.f ====
+incdir+hw
hw/core_pkg.sv
hw/core_decode.sv
hw/core_execute.sv
hw/core_result.sv
hw/core_top.sv
sim/core_props.sv
sim/core_tb.sv

// ==== hw/core_decode.sv ====
// --------------------
// decode stage
// PC and fetch, register file, instruction decode and
// the decode pipeline register
// --------------------

`timescale 1ns/1ps
`include "core_params.svh"

module core_decode (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_exec,
    input  logic [`CORE_XLEN-1:0]   i_fetch_inst,
    input  core_pkg::jump_t         i_jump,
    input  core_pkg::reg_wr_t       i_wr,
    input  logic [`CORE_REG_AW-1:0] i_dbg_addr,
    output logic [`CORE_XLEN-1:0]   o_fetch_pc,
    output core_pkg::dec_t          o_dec,
    output logic [`CORE_XLEN-1:0]   o_dbg_data
);

    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] regs [1:`CORE_NUM_REGS-1];
    core_pkg::inst_u       inst;
    core_pkg::dec_t        dec_d;
    core_pkg::dec_t        dec_q;

    // register read, x0 hard wired, same-cycle write passed through
    function automatic logic [`CORE_XLEN-1:0] rf_read(input logic [`CORE_REG_AW-1:0] idx);
        if (idx == '0)
            return '0;
        else if (i_wr.we && i_wr.rd == idx)
            return i_wr.value;
        else
            return regs[idx];
    endfunction

    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] funct3,
                                                  input logic       bit30,
                                                  input logic       is_op);
        case (funct3)
            3'b000:  return (is_op && bit30) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return bit30 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    // --------------------
    // fetch
    // --------------------
    // a redirect wins even while paused, the jump is already in flight
    always_ff @(posedge i_clk) begin
        if (i_reset)
            pc_q <= `CORE_RESET_PC;
        else if (i_jump.taken)
            pc_q <= i_jump.target;
        else if (i_exec)
            pc_q <= pc_q + 32'd4;
    end

    assign o_fetch_pc = pc_q;
    assign inst       = i_fetch_inst;

    // --------------------
    // register file
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 1; k < `CORE_NUM_REGS; k++)
                regs[k] <= '0;
        end else if (i_wr.we && i_wr.rd != '0) begin
            regs[i_wr.rd] <= i_wr.value;
        end
    end

    always_comb begin
        o_dbg_data = rf_read(i_dbg_addr);
    end

    // --------------------
    // decode
    // --------------------
    always_comb begin
        dec_d         = '0;
        // wrong-path or paused fetch enters as a bubble
        dec_d.valid   = i_exec && !i_jump.taken;
        dec_d.pc      = pc_q;
        dec_d.rd      = inst.r.rd;
        dec_d.rs1     = inst.r.rs1;
        dec_d.rs2     = inst.r.rs2;
        dec_d.funct3  = inst.r.funct3;
        dec_d.imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
        dec_d.alu_op  = alu_sel(inst.r.funct3, inst.r.funct7[5],
                                inst.r.opcode == core_pkg::OPC_OP);
        case (inst.r.opcode)
            core_pkg::OPC_LUI: begin
                // rs1 forced to x0 so operand A reads zero
                dec_d.rs1     = '0;
                dec_d.imm     = {inst.u.imm31_12, 12'b0};
                dec_d.sel_imm = 1'b1;
                dec_d.alu_op  = core_pkg::ALU_ADD;
                dec_d.rd_we   = 1'b1;
            end
            core_pkg::OPC_AUIPC: begin
                dec_d.imm     = {inst.u.imm31_12, 12'b0};
                dec_d.sel_pc  = 1'b1;
                dec_d.sel_imm = 1'b1;
                dec_d.alu_op  = core_pkg::ALU_ADD;
                dec_d.rd_we   = 1'b1;
            end
            core_pkg::OPC_JAL: begin
                dec_d.imm   = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                               inst.j.imm11, inst.j.imm10_1, 1'b0};
                dec_d.jal   = 1'b1;
                dec_d.rd_we = 1'b1;
            end
            core_pkg::OPC_JALR: begin
                dec_d.jalr  = 1'b1;
                dec_d.rd_we = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                dec_d.imm    = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                                inst.b.imm10_5, inst.b.imm4_1, 1'b0};
                dec_d.branch = 1'b1;
            end
            core_pkg::OPC_IMM: begin
                dec_d.sel_imm = 1'b1;
                dec_d.rd_we   = 1'b1;
            end
            core_pkg::OPC_OP: begin
                dec_d.rd_we = 1'b1;
            end
            // anything else passes as a nop
            default: ;
        endcase
        dec_d.rs1_val = rf_read(dec_d.rs1);
        dec_d.rs2_val = rf_read(dec_d.rs2);
    end

    always_ff @(posedge i_clk) begin
        dec_q <= dec_d;
        if (i_reset)
            dec_q.valid <= 1'b0;
    end

    assign o_dec = dec_q;

endmodule

// ==== hw/core_execute.sv ====
// --------------------
// execute stage
// operand forwarding, ALU, branch and jump resolution
// --------------------

`timescale 1ns/1ps
`include "core_params.svh"

module core_execute (
    input  logic              i_clk,
    input  logic              i_reset,
    input  core_pkg::dec_t    i_dec,
    input  core_pkg::reg_wr_t i_fwd_res,
    output core_pkg::jump_t   o_jump,
    output core_pkg::exe_t    o_exe
);

    core_pkg::exe_t        exe_d;
    core_pkg::exe_t        exe_q;
    logic [`CORE_XLEN-1:0] rs1_v;
    logic [`CORE_XLEN-1:0] rs2_v;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [4:0]            shamt;
    logic                  cond;

    // youngest producer first, x0 never matches
    function automatic logic [`CORE_XLEN-1:0] fwd(input logic [`CORE_REG_AW-1:0] idx,
                                                 input logic [`CORE_XLEN-1:0]   dec_val);
        if (idx == '0)
            return dec_val;
        else if (exe_q.valid && exe_q.we && exe_q.rd == idx)
            return exe_q.value;
        else if (i_fwd_res.we && i_fwd_res.rd == idx)
            return i_fwd_res.value;
        else
            return dec_val;
    endfunction

    // --------------------
    // operands and ALU
    // --------------------
    always_comb begin
        rs1_v = fwd(i_dec.rs1, i_dec.rs1_val);
        rs2_v = fwd(i_dec.rs2, i_dec.rs2_val);
    end

    assign op_a  = i_dec.sel_pc ? i_dec.pc : rs1_v;
    assign op_b  = i_dec.sel_imm ? i_dec.imm : rs2_v;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_dec.alu_op)
            core_pkg::ALU_SUB:  alu_res = op_a - op_b;
            core_pkg::ALU_SLL:  alu_res = op_a << shamt;
            core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            core_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            core_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            core_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_OR:   alu_res = op_a | op_b;
            core_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:            alu_res = op_a + op_b;
        endcase
    end

    // --------------------
    // branch and jump
    // --------------------
    always_comb begin
        case (i_dec.funct3)
            3'b000:  cond = rs1_v == rs2_v;
            3'b001:  cond = rs1_v != rs2_v;
            3'b100:  cond = $signed(rs1_v) < $signed(rs2_v);
            3'b101:  cond = $signed(rs1_v) >= $signed(rs2_v);
            3'b110:  cond = rs1_v < rs2_v;
            3'b111:  cond = rs1_v >= rs2_v;
            default: cond = 1'b0;
        endcase
    end

    assign o_jump.taken  = i_dec.valid && (i_dec.jal || i_dec.jalr || (i_dec.branch && cond));
    // jalr clears bit 0 of the sum
    assign o_jump.target = i_dec.jalr ? ((rs1_v + i_dec.imm) & ~32'd1)
                                      : (i_dec.pc + i_dec.imm);

    // --------------------
    // pipeline register
    // --------------------
    always_comb begin
        exe_d.valid = i_dec.valid;
        exe_d.pc    = i_dec.pc;
        exe_d.rd    = i_dec.rd;
        exe_d.we    = i_dec.rd_we;
        exe_d.value = (i_dec.jal || i_dec.jalr) ? i_dec.pc + 32'd4 : alu_res;
    end

    always_ff @(posedge i_clk) begin
        exe_q <= exe_d;
        if (i_reset)
            exe_q.valid <= 1'b0;
    end

    assign o_exe = exe_q;

endmodule

// ==== hw/core_params.svh ====
// --------------------
// core parameters
// widths, register count and reset PC for the RV32I core
// --------------------

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

// integer register file
`define CORE_NUM_REGS 32
`define CORE_REG_AW 5

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== hw/core_pkg.sv ====
// --------------------
// core types
// opcodes, ALU operations, instruction formats and the
// bundles passed between the pipeline stages
// --------------------

`include "core_params.svh"

package core_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_IMM    = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // --------------------
    // instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm31_12;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    // --------------------
    // stage bundles
    // --------------------
    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic                   rd_we;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_XLEN-1:0]   rs1_val;
        logic [`CORE_XLEN-1:0]   rs2_val;
        logic [`CORE_XLEN-1:0]   imm;
        alu_op_e                alu_op;
        logic                   sel_pc;
        logic                   sel_imm;
        logic                   branch;
        logic [2:0]             funct3;
        logic                   jal;
        logic                   jalr;
    } dec_t;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic                   we;
        logic [`CORE_XLEN-1:0]   value;
    } exe_t;

    typedef struct packed {
        logic                   taken;
        logic [`CORE_XLEN-1:0]   target;
    } jump_t;

    typedef struct packed {
        logic                   we;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   value;
    } reg_wr_t;

endpackage

// ==== hw/core_result.sv ====
// --------------------
// result stage
// register-file write and retire reporting
// --------------------

`timescale 1ns/1ps
`include "core_params.svh"

module core_result (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  core_pkg::exe_t        i_exe,
    output core_pkg::reg_wr_t     o_wr,
    output logic                  o_retire,
    output logic [`CORE_XLEN-1:0] o_retire_pc
);

    core_pkg::exe_t res_q;

    always_ff @(posedge i_clk) begin
        res_q <= i_exe;
        if (i_reset)
            res_q.valid <= 1'b0;
    end

    // writes to x0 are dropped here, so they are never forwarded
    assign o_wr.we    = res_q.valid && res_q.we && res_q.rd != '0;
    assign o_wr.rd    = res_q.rd;
    assign o_wr.value = res_q.value;

    assign o_retire    = res_q.valid;
    assign o_retire_pc = res_q.pc;

endmodule

// ==== hw/core_top.sv ====
// --------------------
// RV32I core top
// three stages: decode, execute, result
// --------------------

`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_exec,
    input  logic [`CORE_XLEN-1:0]   i_fetch_inst,
    input  logic [`CORE_REG_AW-1:0] i_dbg_addr,
    output logic [`CORE_XLEN-1:0]   o_fetch_pc,
    output logic                    o_retire,
    output logic [`CORE_XLEN-1:0]   o_retire_pc,
    output logic [`CORE_XLEN-1:0]   o_dbg_data
);

    core_pkg::dec_t    dec;
    core_pkg::exe_t    exe;
    core_pkg::jump_t   jump;
    core_pkg::reg_wr_t wr;

    core_decode u_decode (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_exec       (i_exec),
        .i_fetch_inst (i_fetch_inst),
        .i_jump       (jump),
        .i_wr         (wr),
        .i_dbg_addr   (i_dbg_addr),
        .o_fetch_pc   (o_fetch_pc),
        .o_dec        (dec),
        .o_dbg_data   (o_dbg_data)
    );

    core_execute u_execute (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_dec     (dec),
        .i_fwd_res (wr),
        .o_jump    (jump),
        .o_exe     (exe)
    );

    core_result u_result (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_exe       (exe),
        .o_wr        (wr),
        .o_retire    (o_retire),
        .o_retire_pc (o_retire_pc)
    );

endmodule

// ==== sim/core_props.sv ====
// --------------------
// core properties
// reset, jump target, fetch hold and retire alignment rules
// --------------------

`timescale 1ns/1ps
`include "core_params.svh"

module core_props (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_exec,
    input core_pkg::jump_t       i_jump,
    input logic [`CORE_XLEN-1:0] i_fetch_pc,
    input logic                  i_retire,
    input logic [`CORE_XLEN-1:0] i_retire_pc
);

    int err_cnt = 0;

    // quiet during reset and one cycle past it
    assert property (@(posedge i_clk) i_reset |=> !i_retire ##1 !i_retire)
    else begin
        $error("retire pulsed during or right after reset");
        err_cnt = err_cnt + 1;
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
                     i_jump.taken |-> i_jump.target[0] == 1'b0)
    else begin
        $error("jump target has bit 0 set");
        err_cnt = err_cnt + 1;
    end

    // a redirect may still move the PC while paused
    assert property (@(posedge i_clk) disable iff (i_reset)
                     !i_exec && !i_jump.taken |=> $stable(i_fetch_pc))
    else begin
        $error("fetch PC moved while paused");
        err_cnt = err_cnt + 1;
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
                     i_retire |-> i_retire_pc[1:0] == 2'b00)
    else begin
        $error("retire PC not word aligned");
        err_cnt = err_cnt + 1;
    end

endmodule

// ==== sim/core_tb.sv ====
// --------------------
// RV32I core testbench
// runs a fixed program twice, once without and once with
// random pauses of the run level, then checks every register
// --------------------

`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

    localparam int          PROG_LEN = 42;
    localparam int          NUM_EXP  = 32;
    localparam int          RETIRES  = 36;
    localparam int          WATCHDOG = PROG_LEN * 8 + 100;
    localparam logic [31:0] END_PC   = 32'd164;
    localparam logic [31:0] NOP      = 32'h0000_0013;

    // major opcodes used by the program
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;

    typedef struct packed {
        logic [`CORE_REG_AW-1:0] idx;
        logic [`CORE_XLEN-1:0]   val;
    } exp_t;

    logic                    i_clk;
    logic                    i_reset;
    logic                    i_exec;
    logic [`CORE_XLEN-1:0]   i_fetch_inst;
    logic [`CORE_REG_AW-1:0] i_dbg_addr;
    logic [`CORE_XLEN-1:0]   o_fetch_pc;
    logic                    o_retire;
    logic [`CORE_XLEN-1:0]   o_retire_pc;
    logic [`CORE_XLEN-1:0]   o_dbg_data;

    logic [31:0] prog [PROG_LEN];
    int          seed = 32'hf276_94f5;

    // final register values, worked out by hand
    exp_t exp_tbl [NUM_EXP] = '{
        '{5'd0,  32'h0000_0000},
        '{5'd1,  32'h0000_0005},
        '{5'd2,  32'hffff_fff9},
        '{5'd3,  32'hffff_fff4},
        '{5'd4,  32'hffff_ffff},
        '{5'd5,  32'h0000_0001},
        '{5'd6,  32'h0000_0000},
        '{5'd7,  32'h0000_0001},
        '{5'd8,  32'h0000_0001},
        '{5'd9,  32'h0000_00f5},
        '{5'd10, 32'h0000_03f5},
        '{5'd11, 32'h0000_00f5},
        '{5'd12, 32'h5000_0000},
        '{5'd13, 32'h0fff_ffff},
        '{5'd14, 32'hffff_fffd},
        '{5'd15, 32'h5fff_ffff},
        '{5'd16, 32'h0000_00a0},
        '{5'd17, 32'h07ff_ffff},
        '{5'd18, 32'h0000_00a5},
        '{5'd19, 32'hffff_fffd},
        '{5'd20, 32'h0000_00f5},
        '{5'd21, 32'habcd_e000},
        '{5'd22, 32'h0000_1054},
        '{5'd23, 32'h0000_0005},
        '{5'd24, 32'h0000_0000},
        '{5'd25, 32'h0000_004d},
        '{5'd26, 32'h0000_0021},
        '{5'd27, 32'h0000_008c},
        '{5'd28, 32'h0000_0000},
        '{5'd29, 32'h0000_00a0},
        '{5'd30, 32'h0000_0098},
        '{5'd31, 32'h0000_00a0}
    };

    core_top dut (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_exec       (i_exec),
        .i_fetch_inst (i_fetch_inst),
        .i_dbg_addr   (i_dbg_addr),
        .o_fetch_pc   (o_fetch_pc),
        .o_retire     (o_retire),
        .o_retire_pc  (o_retire_pc),
        .o_dbg_data   (o_dbg_data)
    );

    bind core_top core_props u_props (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_exec      (i_exec),
        .i_jump      (jump),
        .i_fetch_pc  (o_fetch_pc),
        .i_retire    (o_retire),
        .i_retire_pc (o_retire_pc)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // instruction port answers in the same cycle, nop outside the program
    always_comb begin
        if (o_fetch_pc < PROG_LEN * 4)
            i_fetch_inst = prog[o_fetch_pc[31:2]];
        else
            i_fetch_inst = NOP;
    end

    // --------------------
    // instruction encoders
    // --------------------
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic load_program();
        // ALU chain, forwarding at distance 1, 2 and 3
        prog[0]  = i_word(12'd5, 0, 3'b000, 1, OP_IMM);
        prog[1]  = i_word(12'hff4, 1, 3'b000, 2, OP_IMM);
        prog[2]  = r_word(7'h20, 1, 2, 3'b000, 3);
        prog[3]  = r_word(7'h20, 1, 3, 3'b101, 4);
        prog[4]  = r_word(7'h00, 1, 3, 3'b010, 5);
        prog[5]  = r_word(7'h00, 1, 3, 3'b011, 6);
        prog[6]  = i_word(12'hffa, 2, 3'b010, 7, OP_IMM);
        prog[7]  = i_word(12'hfff, 1, 3'b011, 8, OP_IMM);
        prog[8]  = i_word(12'h0f0, 1, 3'b100, 9, OP_IMM);
        prog[9]  = i_word(12'h300, 9, 3'b110, 10, OP_IMM);
        prog[10] = i_word(12'h0ff, 10, 3'b111, 11, OP_IMM);
        prog[11] = i_word(12'd28, 1, 3'b001, 12, OP_IMM);
        prog[12] = i_word(12'd4, 4, 3'b101, 13, OP_IMM);
        prog[13] = i_word(12'h402, 3, 3'b101, 14, OP_IMM);
        prog[14] = r_word(7'h00, 13, 12, 3'b000, 15);
        prog[15] = r_word(7'h00, 1, 1, 3'b001, 16);
        prog[16] = r_word(7'h00, 1, 4, 3'b101, 17);
        prog[17] = r_word(7'h00, 1, 16, 3'b100, 18);
        prog[18] = r_word(7'h00, 2, 18, 3'b110, 19);
        prog[19] = r_word(7'h00, 11, 19, 3'b111, 20);
        // upper immediates, then a write to x0 read right away
        prog[20] = u_word(20'habcde, 21, OP_LUI);
        prog[21] = u_word(20'h00001, 22, OP_AUIPC);
        prog[22] = i_word(12'd7, 1, 3'b000, 0, OP_IMM);
        prog[23] = r_word(7'h00, 1, 0, 3'b000, 23);
        // branches, taken ones skip the next word
        prog[24] = b_word(13'd8, 1, 1, 3'b000);
        prog[25] = i_word(12'd99, 0, 3'b000, 24, OP_IMM);
        prog[26] = b_word(13'd8, 1, 1, 3'b001);
        prog[27] = i_word(12'd77, 0, 3'b000, 25, OP_IMM);
        prog[28] = b_word(13'd8, 1, 3, 3'b100);
        prog[29] = i_word(12'd1, 0, 3'b000, 25, OP_IMM);
        prog[30] = b_word(13'd8, 1, 3, 3'b111);
        prog[31] = i_word(12'd1, 0, 3'b000, 26, OP_IMM);
        prog[32] = b_word(13'd8, 1, 3, 3'b101);
        prog[33] = i_word(12'd33, 0, 3'b000, 26, OP_IMM);
        // jal, then jalr with an odd offset
        prog[34] = j_word(21'd8, 27);
        prog[35] = i_word(12'd1, 0, 3'b000, 28, OP_IMM);
        prog[36] = i_word(12'd160, 0, 3'b000, 29, OP_IMM);
        prog[37] = i_word(12'd1, 29, 3'b000, 30, OP_JALR);
        prog[38] = i_word(12'd2, 0, 3'b000, 28, OP_IMM);
        prog[39] = i_word(12'd3, 0, 3'b000, 28, OP_IMM);
        prog[40] = i_word(12'd8, 30, 3'b000, 31, OP_IMM);
        prog[41] = j_word(21'd0, 0);
    endtask

    // --------------------
    // run control and checks
    // --------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic reset_core();
        @(posedge i_clk);
        i_reset <= 1'b1;
        i_exec  <= 1'b0;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    // runs until the closing jal retires, pausing now and then if asked
    task automatic run_program(input logic paused);
        int   retired;
        int   gap;
        int   pause_left;
        logic done;
        retired    = 0;
        gap        = 0;
        pause_left = 0;
        done       = 1'b0;
        while (!done) begin
            @(posedge i_clk);
            if (paused && pause_left > 0) begin
                i_exec <= 1'b0;
                pause_left = pause_left - 1;
            end else if (paused && gap == 3) begin
                // pause of 1 to 4 cycles
                i_exec <= 1'b0;
                pause_left = $unsigned($random(seed)) % 4;
                gap = 0;
            end else begin
                i_exec <= 1'b1;
                gap = gap + 1;
            end
            @(negedge i_clk);
            if (o_retire) begin
                retired = retired + 1;
                if (o_retire_pc == END_PC)
                    done = 1'b1;
            end
        end
        @(posedge i_clk);
        i_exec <= 1'b0;
        assert (retired == RETIRES)
        else abort_run($sformatf("ERROR: o_retire count got %h expected %h",
                                 retired, RETIRES));
    endtask

    task automatic check_regs();
        exp_t e;
        for (int k = 0; k < NUM_EXP; k++) begin
            e = exp_tbl[k];
            @(posedge i_clk);
            i_dbg_addr <= e.idx;
            @(negedge i_clk);
            assert (o_dbg_data == e.val)
            else abort_run($sformatf("ERROR: o_dbg_data x%0d got %h expected %h",
                                     e.idx, o_dbg_data, e.val));
        end
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge i_clk);
        abort_run($sformatf("timeout: program did not finish within %0d cycles", WATCHDOG));
    end

    initial begin
        i_reset    = 1'b1;
        i_exec     = 1'b0;
        i_dbg_addr = '0;
        load_program();

        // straight run
        reset_core();
        run_program(1'b0);
        check_regs();

        // same program with random pauses
        reset_core();
        run_program(1'b1);
        check_regs();

        if (dut.u_props.err_cnt != 0) begin
            abort_run($sformatf("concurrent assertions failed %0d times",
                                dut.u_props.err_cnt));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
